// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// major opcode, instr[15:12]
	typedef enum logic [3:0] {
		OP_REG   = 4'd0,  // ext picks the operation
		OP_ANDI  = 4'd1,
		OP_ORI   = 4'd2,
		OP_XORI  = 4'd3,
		OP_MEM   = 4'd4,  // load / stor / jcond
		OP_ADDI  = 4'd5,
		OP_LSHI  = 4'd8,  // ext[0]: 0 left, 1 right
		OP_SUBI  = 4'd9,
		OP_CMPI  = 4'd11,
		OP_BCOND = 4'd12,
		OP_MOVI  = 4'd13
	} op_e;

	// extension field, instr[7:4]
	localparam logic [3:0] EXT_AND   = 4'd1;
	localparam logic [3:0] EXT_OR    = 4'd2;
	localparam logic [3:0] EXT_XOR   = 4'd3;
	localparam logic [3:0] EXT_ADD   = 4'd5;
	localparam logic [3:0] EXT_SUB   = 4'd9;
	localparam logic [3:0] EXT_CMP   = 4'd11;
	localparam logic [3:0] EXT_MOV   = 4'd13;
	localparam logic [3:0] EXT_LOAD  = 4'd0;
	localparam logic [3:0] EXT_STOR  = 4'd4;
	localparam logic [3:0] EXT_JCOND = 4'd12;

	typedef enum logic [3:0] {
		ADD, SUB, CMP, AND, OR, XOR, MOV, LSH, RSH
	} alu_fn_e;

	typedef enum logic [3:0] {
		EQ = 4'd0,
		NE = 4'd1,
		CS = 4'd2,
		CC = 4'd3,
		LT = 4'd12, // n xor f
		GE = 4'd13,
		UC = 4'd14
	} cond_e;

	// bit positions in the 5-bit status word
	localparam int FLAG_C = 0;
	localparam int FLAG_L = 1;
	localparam int FLAG_F = 2;
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 4;

	typedef enum logic [1:0] {PC_INC, PC_DISP, PC_TGT, PC_RSVD} pc_mode_e;
	typedef enum logic {ADDR_PC, ADDR_REG} addr_sel_e;
	typedef enum logic {SRC_REG, SRC_IMM} alu_src_e;
	typedef enum logic {WB_ALU, WB_MEM} wb_src_e;

	typedef struct packed {
		logic        pc_en;
		pc_mode_e    pc_mode;
		addr_sel_e   mem_addr_sel;
		logic        mem_we;
		logic        reg_we;
		alu_src_e    alu_src;
		wb_src_e     wb_src;
		alu_fn_e     alu_fn;
		logic [3:0]  rdest;
		logic [3:0]  rsrc;
		logic [15:0] imm; // already extended
	} ctrl_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [15:0] paddr;
		logic [15:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [15:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input  wire [15:0] a,        // rdest
	input  wire [15:0] b,        // rsrc or immediate
	input  wire alu_fn_e fn,
	input  wire [4:0] flags,     // stored flags
	output logic [15:0] result,
	output logic [4:0] flags_next
);

	logic [16:0] sum;
	logic [16:0] diff;
	logic add_ovf;
	logic sub_ovf;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // bit 16 is the borrow
	// signed overflow: operand signs vs result sign
	assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
	assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

	always_comb begin
		result = a;
		flags_next = flags; // untouched unless the op says so
		case (fn)
			ADD: begin
				result = sum[15:0];
				flags_next[FLAG_C] = sum[16];
				flags_next[FLAG_F] = add_ovf;
			end
			SUB: begin
				result = diff[15:0];
				flags_next[FLAG_C] = diff[16];
				flags_next[FLAG_F] = sub_ovf;
			end
			CMP: begin
				// result unused, decoder drops the write
				flags_next[FLAG_L] = diff[16];          // a < b unsigned
				flags_next[FLAG_Z] = (diff[15:0] == 16'd0);
				flags_next[FLAG_N] = diff[15];          // raw sign
				flags_next[FLAG_F] = sub_ovf;           // so lt = n ^ f
			end
			AND: result = a & b;
			OR:  result = a | b;
			XOR: result = a ^ b;
			MOV: result = b;
			LSH: result = a << b[3:0];
			RSH: result = a >> b[3:0]; // logical
			default: result = a;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
	input  wire clk,
	input  wire reset,
	input  wire we,
	input  wire [3:0] waddr,
	input  wire [15:0] wdata,
	input  wire [3:0] raddr_a,
	input  wire [3:0] raddr_b,
	output logic [15:0] rdata_a,
	output logic [15:0] rdata_b
);

	logic [15:0] regs [16];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'd0;
			end
		end else if (we) begin
			regs[waddr] <= wdata; // one register per edge
		end
	end

	// combinational reads, no bypass
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// File: rtl/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter import cpu_pkg::*; (
	input  wire clk,
	input  wire reset,
	input  wire en,              // last cycle of an instruction
	input  wire pc_mode_e mode,
	input  wire [15:0] disp,     // signed, relative to this instr
	input  wire [15:0] target,   // jump register
	output logic [15:0] pc
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= 16'd0;
		end else if (en) begin
			case (mode)
				PC_DISP: pc <= pc + disp; // disp 0 spins in place
				PC_TGT:  pc <= target;
				default: pc <= pc + 16'd1;
			endcase
		end
	end

	// decoder never hands over the spare mode
	a_mode_legal: assert property (@(posedge clk) disable iff (!reset)
		en |-> mode != PC_RSVD);

endmodule

`default_nettype wire

// File: rtl/control_and_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_and_decoder import cpu_pkg::*; (
	input  wire clk,
	input  wire reset,
	input  wire run,              // core held in fetch while low
	input  wire [15:0] instr,     // q_a
	input  wire [4:0] flags_next, // from alu
	output logic [4:0] flags,     // stored status word
	output ctrl_t ctrl
);

	typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, WRITEBACK} state_e;

	state_e state;
	logic [15:0] ir;
	op_e op;
	logic [3:0] ext;
	logic is_load;
	logic taken;
	logic [15:0] sext8;
	logic [15:0] zext8;
	ctrl_t dec; // decoded from ir before state gating

	function automatic logic cond_true(input cond_e cc, input logic [4:0] f);
		case (cc)
			EQ: return f[FLAG_Z];
			NE: return !f[FLAG_Z];
			CS: return f[FLAG_C];
			CC: return !f[FLAG_C];
			LT: return f[FLAG_N] ^ f[FLAG_F];
			GE: return !(f[FLAG_N] ^ f[FLAG_F]);
			UC: return 1'b1;
			default: return 1'b0; // unknown code never taken
		endcase
	endfunction

	assign op = op_e'(ir[15:12]);
	assign ext = ir[7:4];
	assign is_load = (op == OP_MEM) && (ext == EXT_LOAD);
	assign taken = cond_true(cond_e'(ir[11:8]), flags);
	assign sext8 = {{8{ir[7]}}, ir[7:0]};
	assign zext8 = {8'd0, ir[7:0]};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= FETCH;
			ir <= 16'd0; // decodes as a nop
			flags <= 5'd0;
		end else begin
			case (state)
				FETCH:     if (run) state <= DECODE;
				DECODE:    state <= EXECUTE;
				EXECUTE:   state <= is_load ? WRITEBACK : FETCH;
				WRITEBACK: state <= FETCH;
			endcase
			if (state == DECODE) ir <= instr; // read data lands here
			if (ctrl.pc_en) flags <= flags_next; // flags move with pc
		end
	end

	always_comb begin
		dec = '0;
		dec.alu_fn = MOV; // mov keeps the flags
		dec.rdest = ir[11:8];
		dec.rsrc = ir[3:0];
		case (op)
			OP_REG: begin
				dec.reg_we = 1'b1;
				case (ext)
					EXT_ADD: dec.alu_fn = ADD;
					EXT_SUB: dec.alu_fn = SUB;
					EXT_AND: dec.alu_fn = AND;
					EXT_OR:  dec.alu_fn = OR;
					EXT_XOR: dec.alu_fn = XOR;
					EXT_MOV: dec.alu_fn = MOV;
					EXT_CMP: begin
						dec.alu_fn = CMP;
						dec.reg_we = 1'b0; // flags only
					end
					default: dec.reg_we = 1'b0;
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				dec.reg_we = 1'b1;
				dec.alu_src = SRC_IMM;
				dec.imm = zext8;
				dec.alu_fn = (op == OP_ANDI) ? AND : (op == OP_ORI) ? OR : XOR;
			end
			OP_ADDI, OP_SUBI, OP_MOVI: begin
				dec.reg_we = 1'b1;
				dec.alu_src = SRC_IMM;
				dec.imm = sext8;
				dec.alu_fn = (op == OP_ADDI) ? ADD : (op == OP_SUBI) ? SUB : MOV;
			end
			OP_CMPI: begin
				dec.alu_src = SRC_IMM;
				dec.imm = sext8;
				dec.alu_fn = CMP;
			end
			OP_LSHI: begin
				dec.reg_we = 1'b1;
				dec.alu_src = SRC_IMM;
				dec.imm = {12'd0, ir[3:0]}; // amount sits in the rsrc field
				dec.alu_fn = ext[0] ? RSH : LSH;
			end
			OP_MEM: begin
				if (ext == EXT_LOAD || ext == EXT_STOR) dec.mem_addr_sel = ADDR_REG;
				if (ext == EXT_STOR) dec.mem_we = 1'b1;
				if (ext == EXT_JCOND && taken) dec.pc_mode = PC_TGT;
			end
			OP_BCOND: begin
				dec.imm = sext8; // displacement
				if (taken) dec.pc_mode = PC_DISP;
			end
			default: ; // reserved opcode runs as a nop
		endcase
	end

	// let the decode through only where the state allows writes
	always_comb begin
		ctrl = dec;
		ctrl.pc_en = 1'b0;
		ctrl.mem_we = 1'b0;
		ctrl.reg_we = 1'b0;
		ctrl.mem_addr_sel = ADDR_PC; // fetch address otherwise
		case (state)
			EXECUTE: begin
				ctrl.pc_en = !is_load; // load finishes in writeback
				ctrl.mem_we = dec.mem_we;
				ctrl.reg_we = dec.reg_we;
				ctrl.mem_addr_sel = dec.mem_addr_sel; // load address goes out here
			end
			WRITEBACK: begin
				ctrl.pc_en = 1'b1;
				ctrl.pc_mode = PC_INC;
				ctrl.reg_we = 1'b1;
				ctrl.wb_src = WB_MEM;
			end
			default: ;
		endcase
	end

	// state register never holds an unknown code
	a_state_known: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown(state));

	a_we_excl: assert property (@(posedge clk) disable iff (!reset)
		!(ctrl.mem_we && ctrl.reg_we));

endmodule

`default_nettype wire

// File: rtl/program_memory.sv
`timescale 1ns/1ps
`default_nettype none

module program_memory import cpu_pkg::*; #(
	parameter int MEM_AW = 10
) (
	input  wire clk,
	input  wire reset,
	input  wire [MEM_AW-1:0] addr_a, // core side
	input  wire [15:0] wdata_a,
	input  wire we_a,
	output logic [15:0] q_a,
	input  wire apb_req_t apb_req,   // port b
	output apb_rsp_t apb_rsp
);

	logic [15:0] mem [2**MEM_AW];
	logic [MEM_AW-1:0] addr_b;
	logic in_range;
	logic setup;
	logic access;
	logic we_b;
	logic [15:0] q_b;
	logic err_q; // range miss seen in setup

	assign addr_b = apb_req.paddr[MEM_AW-1:0];
	assign in_range = (apb_req.paddr >> MEM_AW) == 16'd0;
	assign setup = apb_req.psel && !apb_req.penable;
	assign access = apb_req.psel && apb_req.penable;
	assign we_b = access && apb_req.pwrite && in_range; // bad address dropped

	always_ff @(posedge clk) begin
		if (we_a) mem[addr_a] <= wdata_a;
		if (we_b) mem[addr_b] <= apb_req.pwdata;
		q_a <= mem[addr_a];             // one cycle read
		if (setup) q_b <= mem[addr_b];  // ready for the access cycle
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			err_q <= 1'b0;
		end else begin
			err_q <= setup && !in_range;
		end
	end

	// zero wait states
	assign apb_rsp = '{prdata: q_b, pready: 1'b1, pslverr: access && err_q};

	a_apb_enable: assert property (@(posedge clk) disable iff (!reset)
		apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
	parameter int MEM_AW = 10
) (
	input  wire clk,
	input  wire reset,
	input  wire run,
	input  wire apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic [15:0] out // alu result, always visible
);

	ctrl_t ctrl;
	logic [4:0] flags;
	logic [4:0] flags_next;
	logic [15:0] pc;
	logic [15:0] q_a;
	logic [15:0] rdata_a;    // rdest
	logic [15:0] rdata_b;    // rsrc
	logic [15:0] alu_b;
	logic [15:0] alu_result;
	logic [15:0] wb_data;
	logic [MEM_AW-1:0] mem_addr;

	// port a address, wraps to depth
	assign mem_addr = (ctrl.mem_addr_sel == ADDR_REG) ? rdata_b[MEM_AW-1:0]
		: pc[MEM_AW-1:0];
	assign alu_b = (ctrl.alu_src == SRC_IMM) ? ctrl.imm : rdata_b;
	assign wb_data = (ctrl.wb_src == WB_MEM) ? q_a : alu_result;
	assign out = alu_result;

	control_and_decoder control_and_decoder_i (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.instr      (q_a),
		.flags_next (flags_next),
		.flags      (flags),
		.ctrl       (ctrl)
	);

	program_counter program_counter_i (
		.clk    (clk),
		.reset  (reset),
		.en     (ctrl.pc_en),
		.mode   (ctrl.pc_mode),
		.disp   (ctrl.imm),   // branch displacement
		.target (rdata_b),    // jcond register
		.pc     (pc)
	);

	regfile regfile_i (
		.clk     (clk),
		.reset   (reset),
		.we      (ctrl.reg_we),
		.waddr   (ctrl.rdest),
		.wdata   (wb_data),
		.raddr_a (ctrl.rdest),
		.raddr_b (ctrl.rsrc),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	alu alu_i (
		.a          (rdata_a),
		.b          (alu_b),
		.fn         (ctrl.alu_fn),
		.flags      (flags),
		.result     (alu_result),
		.flags_next (flags_next)
	);

	program_memory #(
		.MEM_AW (MEM_AW)
	) program_memory_i (
		.clk     (clk),
		.reset   (reset),
		.addr_a  (mem_addr),
		.wdata_a (rdata_a), // stor data from rdest
		.we_a    (ctrl.mem_we),
		.q_a     (q_a),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

endmodule

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	localparam int MEM_AW = 10;
	localparam logic [15:0] MAILBOX = 16'h03F0;   // done flag lives here
	localparam logic [15:0] DONE_MARK = 16'hD0E5;
	localparam logic [15:0] RES_BASE = 16'h0300;  // result area above any program

	logic clk;
	logic reset;
	logic run;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic [15:0] out;

	int errors;
	logic [31:0] lcg_state;
	logic [15:0] prog [$]; // program image from word 0
	logic watch_out;
	logic out_seen [65536]; // values seen on out while watched

	cpu_top #(
		.MEM_AW (MEM_AW)
	) cpu_top_i (
		.clk     (clk),
		.reset   (reset),
		.run     (run),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.out     (out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// out is settled mid cycle
	always @(negedge clk) begin
		if (watch_out) out_seen[out] = 1'b1;
	end

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16]; // upper bits spread better
	endfunction

	function automatic logic [15:0] sign_ext(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	// instruction encoders
	function automatic logic [15:0] reg_op(input logic [3:0] ext, input logic [3:0] rd,
		input logic [3:0] rs);
		return {OP_REG, rd, ext, rs};
	endfunction

	function automatic logic [15:0] imm_op(input op_e op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] mem_op(input logic [3:0] ext, input logic [3:0] rd,
		input logic [3:0] rs);
		return {OP_MEM, rd, ext, rs};
	endfunction

	function automatic logic [15:0] branch_op(input cond_e cc, input logic [7:0] disp);
		return {OP_BCOND, cc, disp};
	endfunction

	task automatic put_word(input logic [15:0] w);
		prog.push_back(w);
	endtask

	// any 16-bit constant in three words that leave the flags alone
	task automatic build_const(input logic [3:0] rd, input logic [15:0] v);
		put_word(imm_op(OP_MOVI, rd, v[15:8]));
		put_word(imm_op(OP_LSHI, rd, 8'h08));   // sign bits shifted out
		put_word(imm_op(OP_ORI, rd, v[7:0]));
	endtask

	task automatic store_reg_to(input logic [3:0] rd, input logic [15:0] addr);
		build_const(4'd15, addr); // r15 is the address register
		put_word(mem_op(EXT_STOR, rd, 4'd15));
	endtask

	task automatic end_with_marker();
		build_const(4'd14, DONE_MARK);
		store_reg_to(4'd14, MAILBOX);
		put_word(branch_op(UC, 8'h00)); // spin on itself
	endtask

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp) else begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// setup then access then idle with prdata and pslverr sampled mid access
	task automatic apb_transfer(input logic write, input logic [15:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= write;
		apb_req.paddr <= addr;
		apb_req.pwdata <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		assert (apb_rsp.pready === 1'b1) else begin
			$display("pready was not high in the access cycle to address %h", addr);
			errors++;
		end
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= 1'b0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [15:0] data,
		output logic err);
		logic [15:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [15:0] data,
		output logic err);
		apb_transfer(1'b0, addr, 16'h0000, data, err);
	endtask

	task automatic expect_word(input string name, input logic [15:0] addr,
		input logic [15:0] exp);
		logic [15:0] data;
		logic err;
		apb_read(addr, data, err);
		check_value(name, exp, data);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b0;
		run <= 1'b0;   // core parked in fetch
		repeat (5) @(posedge clk);
		reset <= 1'b1;
	endtask

	task automatic load_program();
		logic err;
		assert (prog.size() < RES_BASE) else begin
			$display("program of %0d words runs into the result area", prog.size());
			errors++;
		end
		foreach (prog[i]) begin
			apb_write(16'(i), prog[i], err);
		end
		apb_write(MAILBOX, 16'h0000, err); // marker of the previous run
		@(posedge clk);
		run <= 1'b1;
	endtask

	task automatic wait_done(input string name);
		logic [15:0] data;
		logic err;
		int cycles;
		data = 16'h0000;
		// each poll is one three-cycle read
		for (cycles = 0; cycles < 2000 && data !== DONE_MARK; cycles += 3) begin
			apb_read(MAILBOX, data, err);
		end
		assert (data === DONE_MARK) else begin
			$display("%s: core did not store the done marker within 2000 cycles", name);
			errors++;
		end
	endtask

	task automatic apb_port_checks();
		logic [15:0] addr [4];
		logic [15:0] data [4];
		logic [15:0] rd;
		logic err;
		apply_reset();
		apb_read(16'h0010, rd, err);
		check_value("apb pslverr after reset", 16'd0, {15'd0, err});
		addr = '{16'h0000, 16'h0155, 16'h02AA, 16'h03FF}; // top word included
		foreach (addr[k]) begin
			data[k] = next_rand();
			apb_write(addr[k], data[k], err);
			check_value("apb write pslverr", 16'd0, {15'd0, err});
		end
		foreach (addr[k]) begin
			expect_word($sformatf("apb readback %0d", k), addr[k], data[k]);
		end
		// 0x0405 aliases 0x0005 if the range check is missing
		apb_write(16'h0005, 16'h1111, err);
		apb_write(16'h0405, 16'h2222, err);
		check_value("apb write out of range", 16'd1, {15'd0, err});
		apb_read(16'hFFFF, rd, err);
		check_value("apb read out of range", 16'd1, {15'd0, err});
		expect_word("apb dropped write", 16'h0005, 16'h1111);
	endtask

	task automatic alu_program();
		logic [15:0] a;
		logic [15:0] b;
		logic [7:0] imm [6];
		logic [15:0] exp [12];
		a = next_rand();
		b = next_rand();
		foreach (imm[k]) begin
			imm[k] = 8'(next_rand());
		end
		apply_reset();
		prog.delete();
		build_const(4'd1, a);
		build_const(4'd2, b);
		put_word(imm_op(OP_MOVI, 4'd3, imm[0]));
		store_reg_to(4'd3, RES_BASE);
		for (int k = 1; k < 12; k++) begin
			put_word(reg_op(EXT_MOV, 4'd4, 4'd1)); // fresh copy of a
			case (k)
				1: put_word(imm_op(OP_ADDI, 4'd4, imm[1]));
				2: put_word(imm_op(OP_SUBI, 4'd4, imm[2]));
				3: put_word(imm_op(OP_ANDI, 4'd4, imm[3]));
				4: put_word(imm_op(OP_ORI, 4'd4, imm[4]));
				5: put_word(imm_op(OP_XORI, 4'd4, imm[5]));
				6: put_word(reg_op(EXT_ADD, 4'd4, 4'd2));
				7: put_word(reg_op(EXT_SUB, 4'd4, 4'd2));
				8: put_word(reg_op(EXT_AND, 4'd4, 4'd2));
				9: put_word(reg_op(EXT_OR, 4'd4, 4'd2));
				10: put_word(reg_op(EXT_XOR, 4'd4, 4'd2));
				default: put_word(reg_op(EXT_MOV, 4'd4, 4'd2));
			endcase
			store_reg_to(4'd4, RES_BASE + 16'(k));
		end
		end_with_marker();
		// arithmetic immediates sign extend while logical ones zero extend
		exp[0] = sign_ext(imm[0]);
		exp[1] = a + sign_ext(imm[1]);
		exp[2] = a - sign_ext(imm[2]);
		exp[3] = a & {8'h00, imm[3]};
		exp[4] = a | {8'h00, imm[4]};
		exp[5] = a ^ {8'h00, imm[5]};
		exp[6] = a + b;
		exp[7] = a - b;
		exp[8] = a & b;
		exp[9] = a | b;
		exp[10] = a ^ b;
		exp[11] = b;
		foreach (out_seen[v]) begin
			out_seen[v] = 1'b0;
		end
		load_program();
		watch_out = 1'b1;
		wait_done("alu program");
		watch_out = 1'b0;
		foreach (exp[k]) begin
			expect_word($sformatf("alu op %0d", k), RES_BASE + 16'(k), exp[k]);
			// each result shows on out in its execute cycle
			assert (out_seen[exp[k]] === 1'b1) else begin
				$display("alu op %0d result %h never appeared on out", k, exp[k]);
				errors++;
			end
		end
	endtask

	task automatic shift_compare_program();
		logic [15:0] a;
		logic [15:0] x;
		logic [15:0] y;
		logic [3:0] sl;
		logic [3:0] sr;
		logic [7:0] ci;
		logic [15:0] lhs [3];
		logic [15:0] rhs [3];
		cond_e conds [6];
		logic taken;
		a = next_rand();
		x = next_rand();
		y = next_rand();
		sl = 4'(next_rand());
		sr = 4'(next_rand());
		ci = 8'(next_rand());
		conds = '{EQ, NE, LT, GE, CS, CC};
		lhs = '{x, x, y};             // random then equal then immediate round
		rhs = '{y, x, sign_ext(ci)};
		apply_reset();
		prog.delete();
		build_const(4'd1, a);
		put_word(reg_op(EXT_MOV, 4'd4, 4'd1));
		put_word(imm_op(OP_LSHI, 4'd4, {4'h0, sl}));
		store_reg_to(4'd4, RES_BASE + 16'h40);
		put_word(reg_op(EXT_MOV, 4'd4, 4'd1));
		put_word(imm_op(OP_LSHI, 4'd4, {4'h1, sr})); // ext low bit selects right
		store_reg_to(4'd4, RES_BASE + 16'h41);
		build_const(4'd1, x);
		build_const(4'd2, y);
		put_word(reg_op(EXT_MOV, 4'd3, 4'd1));
		for (int r = 0; r < 3; r++) begin
			// sub on scratch r5 sets carry and compare leaves it alone
			case (r)
				0: begin
					put_word(reg_op(EXT_MOV, 4'd5, 4'd1));
					put_word(reg_op(EXT_SUB, 4'd5, 4'd2));
					put_word(reg_op(EXT_CMP, 4'd1, 4'd2));
				end
				1: begin
					put_word(reg_op(EXT_MOV, 4'd5, 4'd1));
					put_word(reg_op(EXT_SUB, 4'd5, 4'd3));
					put_word(reg_op(EXT_CMP, 4'd1, 4'd3));
				end
				default: begin
					put_word(reg_op(EXT_MOV, 4'd5, 4'd2));
					put_word(imm_op(OP_SUBI, 4'd5, ci));
					put_word(imm_op(OP_CMPI, 4'd2, ci));
				end
			endcase
			foreach (conds[c]) begin
				put_word(imm_op(OP_MOVI, 4'd6, 8'h01));    // taken tag
				put_word(branch_op(conds[c], 8'h02));     // skip the next word
				put_word(imm_op(OP_MOVI, 4'd6, 8'h02));    // not taken tag
				store_reg_to(4'd6, RES_BASE + 16'h50 + 16'(r * 6 + c));
			end
		end
		end_with_marker();
		load_program();
		wait_done("shift and compare program");
		expect_word("lshi left", RES_BASE + 16'h40, a << sl);
		expect_word("lshi right", RES_BASE + 16'h41, a >> sr);
		for (int r = 0; r < 3; r++) begin
			foreach (conds[c]) begin
				case (conds[c])
					EQ: taken = lhs[r] == rhs[r];
					NE: taken = lhs[r] != rhs[r];
					LT: taken = $signed(lhs[r]) < $signed(rhs[r]);
					GE: taken = $signed(lhs[r]) >= $signed(rhs[r]);
					CS: taken = lhs[r] < rhs[r];  // borrow out of the sub
					default: taken = lhs[r] >= rhs[r];
				endcase
				expect_word($sformatf("compare round %0d %s", r, conds[c].name()),
					RES_BASE + 16'h50 + 16'(r * 6 + c), taken ? 16'h0001 : 16'h0002);
			end
		end
	endtask

	task automatic load_store_program();
		logic [15:0] data [4];
		logic [7:0] imm [4];
		logic err;
		apply_reset();
		prog.delete();
		foreach (data[k]) begin
			data[k] = next_rand();
			imm[k] = 8'(next_rand());
			apb_write(16'h0380 + 16'(k), data[k], err); // source words
		end
		foreach (data[k]) begin
			build_const(4'd15, 16'h0380 + 16'(k));
			put_word(mem_op(EXT_LOAD, 4'd2, 4'd15));
			put_word(imm_op(OP_ADDI, 4'd2, imm[k]));
			store_reg_to(4'd2, 16'h0390 + 16'(k));
		end
		end_with_marker();
		load_program();
		wait_done("load and store program");
		foreach (data[k]) begin
			expect_word($sformatf("load store %0d", k), 16'h0390 + 16'(k),
				data[k] + sign_ext(imm[k]));
		end
	endtask

	task automatic jump_loop_program();
		logic [15:0] target;
		logic [15:0] n;
		logic [15:0] sum;
		logic err;
		n = (next_rand() % 16'd30) + 16'd1;
		sum = 16'd0;
		for (int k = 1; k <= int'(n); k++) begin
			sum += 16'(k);
		end
		apply_reset();
		apb_write(16'h03A0, 16'h5A5A, err); // must survive the skipped store
		apb_write(16'h03A1, 16'h0000, err);
		prog.delete();
		target = 16'(prog.size()) + 16'd9;  // three const words and the jump before five skipped
		build_const(4'd7, target);
		put_word(mem_op(EXT_JCOND, UC, 4'd7));
		put_word(imm_op(OP_MOVI, 4'd6, 8'hBD));
		store_reg_to(4'd6, 16'h03A0);
		put_word(reg_op(EXT_CMP, 4'd7, 4'd7)); // z set so jne falls through
		put_word(mem_op(EXT_JCOND, NE, 4'd7));
		put_word(imm_op(OP_MOVI, 4'd6, 8'h3C));
		store_reg_to(4'd6, 16'h03A1);
		put_word(imm_op(OP_MOVI, 4'd1, n[7:0]));  // counter
		put_word(imm_op(OP_MOVI, 4'd2, 8'h00));   // sum
		put_word(reg_op(EXT_ADD, 4'd2, 4'd1));
		put_word(imm_op(OP_SUBI, 4'd1, 8'h01));
		put_word(imm_op(OP_CMPI, 4'd1, 8'h00));
		put_word(branch_op(NE, 8'hFD));           // back to the add
		store_reg_to(4'd2, 16'h03A2);
		end_with_marker();
		load_program();
		wait_done("jump and loop program");
		expect_word("jcond skip", 16'h03A0, 16'h5A5A);
		expect_word("jcond fall through", 16'h03A1, 16'h003C);
		expect_word("loop sum", 16'h03A2, sum);
	endtask

	initial begin
		reset <= 1'b0;
		run <= 1'b0;
		apb_req <= '0;
		errors = 0;
		watch_out = 1'b0;
		lcg_state = 32'd25;
		apb_port_checks();
		alu_program();
		shift_compare_program();
		load_store_program();
		jump_loop_program();
		$display("checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/program_counter.sv
rtl/control_and_decoder.sv
rtl/program_memory.sv
rtl/cpu_top.sv
bench/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - rtl/cpu_pkg.sv
  - rtl/alu.sv
  - rtl/regfile.sv
  - rtl/program_counter.sv
  - rtl/control_and_decoder.sv
  - rtl/program_memory.sv
  - rtl/cpu_top.sv
  - target: simulation
    files:
      - bench/cpu_tb.sv
